// File: verilog/cart_cfg.svh
// Cartridge loader configuration
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

// Download bus widths
`define CART_ADDR_W 25
`define CART_DATA_W 16

// Header byte addresses
`define CART_HDR_REGION_A 'h1F0
`define CART_HDR_REGION_B 'h1F2
`define CART_HDR_END      'h200
`define CART_ID_FIRST     'h182  // Serial starts at high byte
`define CART_ID_DECIDE    'h18C  // Serial complete, run the lookup

// Region letters in the header
`define CART_CHAR_J "J"
`define CART_CHAR_U "U"
`define CART_CHAR_E "E"

`define CART_BK_SECTORS        128
`define CART_GUN_DELAY_DEFAULT 8'd44

// Serial numbers, space padded to eight characters
`define CART_SN_SRAM_A   "T-081276"
`define CART_SN_SRAM_B   "T-81406 "
`define CART_SN_EEPROM_A "MK-1215 "
`define CART_SN_EEPROM_B "G-4060  "
`define CART_SN_NORAM    "T-113016"
`define CART_SN_FIFO     "T-89016 "
`define CART_SN_PIER     "T-574023"
`define CART_SN_SVP_A    "MK-1229 "
`define CART_SN_SVP_B    "G-7001  "
`define CART_SN_FMBUSY   "T-35036 "
`define CART_SN_SCHAN    "T-68???-"
`define CART_SN_GUN_BODY "MK-1533 "
`define CART_SN_GUN_LE1  "T-95096-"
`define CART_SN_GUN_LE2  "T-95136-"
`define CART_SN_GUN_MEN  "MK-1658 "
`define CART_SN_GUN_T2   "T-081156"

`endif

// File: verilog/cart_pkg.sv
// Cartridge loader types
package cart_pkg;

	// Console region, same coding as the region menu
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Preferred order when the header lists several regions
	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	// Source of the automatic region, 3 acts as disabled too
	typedef enum logic [1:0] {
		MODE_FILE_EXT = 2'd0,
		MODE_HEADER   = 2'd1,
		MODE_DISABLED = 2'd2
	} region_mode_t;

	typedef struct packed {
		logic j;
		logic u;
		logic e;
	} region_flags_t;

	typedef struct packed {
		logic       sram;
		logic       eeprom;
		logic       noram;
		logic       fifo;
		logic       pier;
		logic       svp;
		logic       fmbusy;
		logic       schan;
		logic       gun_type;          // 0 menacer style, 1 justifier style
		logic [7:0] gun_sensor_delay;
	} cart_quirks_t;

endpackage

// File: verilog/rom_write_pacer.sv
// ROM download write pacer
`timescale 1ns/1ns
`include "cart_cfg.svh"

module rom_write_pacer (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [`CART_DATA_W-1:0] ioctl_data,
	input  logic                    rom_ack,
	output logic                    rom_req,
	output logic [`CART_ADDR_W-2:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_wdata,
	output logic                    ioctl_wait,
	output logic [`CART_ADDR_W-1:0] rom_size
);

	logic dl_d;
	logic rom_wr;

	assign rom_wr = ioctl_download & ioctl_wr;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_d       <= 1'b0;
			rom_req    <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			dl_d <= ioctl_download;
			if (rom_wr) begin
				ioctl_wait <= 1'b1;
				rom_req    <= ~rom_req;          // One toggle per word
			end else if (ioctl_wait && (rom_ack == rom_req)) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Word address and byte-swapped data for the memory
	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			rom_addr  <= ioctl_addr[`CART_ADDR_W-1:1];
			rom_wdata <= {ioctl_data[`CART_DATA_W/2-1:0], ioctl_data[`CART_DATA_W-1:`CART_DATA_W/2]};
		end
		if (dl_d && !ioctl_download) rom_size <= ioctl_addr;  // Last address of the image
	end

	// Source must hold off while a word is in flight
	wr_during_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |-> !ioctl_wr);

endmodule

// File: verilog/header_region_scan.sv
// Header region scanner
`timescale 1ns/1ns
`include "cart_cfg.svh"

module header_region_scan (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [`CART_DATA_W-1:0] ioctl_data,
	output cart_pkg::region_flags_t hdr_flags,
	output logic                    hdr_ready
);

	logic                    dl_d;
	logic [7:0]              lo_byte;
	logic [7:0]              hi_byte;
	logic [3:0]              hex_val;
	cart_pkg::region_flags_t next_flags;

	// J, U or E as a single flag
	function automatic cart_pkg::region_flags_t letter_flags(input logic [7:0] ch);
		cart_pkg::region_flags_t f;
		f = '0;
		if (ch == `CART_CHAR_J) f.j = 1'b1;
		else if (ch == `CART_CHAR_U) f.u = 1'b1;
		else if (ch == `CART_CHAR_E) f.e = 1'b1;
		return f;
	endfunction

	assign lo_byte = ioctl_data[7:0];
	assign hi_byte = ioctl_data[15:8];
	assign hex_val = ioctl_data[3:0] - 4'd7;  // 'A'..'F' to 10..15

	always_comb begin
		next_flags = hdr_flags;
		if (ioctl_addr == `CART_HDR_REGION_A) begin
			if (letter_flags(lo_byte) != '0)
				next_flags = cart_pkg::region_flags_t'(hdr_flags | letter_flags(lo_byte));
			else if (lo_byte >= "0" && lo_byte <= "9")
				next_flags = '{j: ioctl_data[0], u: ioctl_data[2], e: ioctl_data[3]};
			else if (lo_byte >= "A" && lo_byte <= "F")
				next_flags = '{j: hex_val[0], u: hex_val[2], e: hex_val[3]};
			// High byte may carry a second letter
			next_flags = cart_pkg::region_flags_t'(next_flags | letter_flags(hi_byte));
		end else if (ioctl_addr == `CART_HDR_REGION_B) begin
			next_flags = cart_pkg::region_flags_t'(hdr_flags | letter_flags(lo_byte));
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_d      <= 1'b0;
			hdr_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_d <= ioctl_download;
			if (!dl_d && ioctl_download) hdr_flags <= '0;  // New image
			if (dl_d && !ioctl_download) hdr_ready <= 1'b0;
			if (ioctl_download && ioctl_wr) begin
				hdr_flags <= next_flags;
				if (ioctl_addr == `CART_HDR_END) hdr_ready <= 1'b1;
			end
		end
	end

endmodule

// File: verilog/cart_id_quirks.sv
// Serial number quirk decoder
`timescale 1ns/1ns
`include "cart_cfg.svh"

module cart_id_quirks (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [`CART_DATA_W-1:0] ioctl_data,
	output cart_pkg::cart_quirks_t  quirks
);

	logic                   dl_d;
	logic                   id_wr;
	logic [63:0]            cart_id;  // Eight ASCII characters
	cart_pkg::cart_quirks_t hit;

	assign id_wr = ioctl_download & ioctl_wr;

	// Serial assembly, low byte of each word comes first
	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			if (ioctl_addr == `CART_ID_FIRST)     cart_id[63:56] <= ioctl_data[15:8];
			if (ioctl_addr == `CART_ID_FIRST + 2) cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == `CART_ID_FIRST + 4) cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == `CART_ID_FIRST + 6) cart_id[23:8]  <= {ioctl_data[7:0], ioctl_data[15:8]};
			if (ioctl_addr == `CART_ID_FIRST + 8) cart_id[7:0]   <= ioctl_data[7:0];
		end
	end

	////////////////////////////////////////
	// Lookup tables
	always_comb begin
		hit = '0;
		hit.gun_sensor_delay = `CART_GUN_DELAY_DEFAULT;

		if (cart_id == `CART_SN_SRAM_A || cart_id == `CART_SN_SRAM_B) hit.sram = 1'b1;
		else if (cart_id == `CART_SN_EEPROM_A || cart_id == `CART_SN_EEPROM_B) hit.eeprom = 1'b1;
		else if (cart_id == `CART_SN_NORAM) hit.noram = 1'b1;   // Fake RAM check
		else if (cart_id == `CART_SN_FIFO) hit.fifo = 1'b1;
		else if (cart_id == `CART_SN_PIER) hit.pier = 1'b1;
		else if (cart_id == `CART_SN_SVP_A || cart_id == `CART_SN_SVP_B) hit.svp = 1'b1;
		else if (cart_id == `CART_SN_FMBUSY) hit.fmbusy = 1'b1;
		else if (cart_id == `CART_SN_SCHAN) hit.schan = 1'b1;   // Question marks are literal

		// Light gun type and sensor offset
		if (cart_id == `CART_SN_GUN_BODY) begin
			hit.gun_sensor_delay = 8'd100;
		end else if (cart_id == `CART_SN_GUN_LE1) begin
			hit.gun_type         = 1'b1;
			hit.gun_sensor_delay = 8'd52;
		end else if (cart_id == `CART_SN_GUN_LE2) begin
			hit.gun_type         = 1'b1;
			hit.gun_sensor_delay = 8'd30;
		end else if (cart_id == `CART_SN_GUN_MEN) begin
			hit.gun_sensor_delay = 8'd120;
		end else if (cart_id == `CART_SN_GUN_T2) begin
			hit.gun_sensor_delay = 8'd126;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_d   <= 1'b0;
			quirks <= '0;
			quirks.gun_sensor_delay <= `CART_GUN_DELAY_DEFAULT;
		end else begin
			dl_d <= ioctl_download;
			if (!dl_d && ioctl_download) begin  // Flags only, gun timing stays
				quirks.sram   <= 1'b0;
				quirks.eeprom <= 1'b0;
				quirks.noram  <= 1'b0;
				quirks.fifo   <= 1'b0;
				quirks.pier   <= 1'b0;
				quirks.svp    <= 1'b0;
				quirks.fmbusy <= 1'b0;
				quirks.schan  <= 1'b0;
			end
			if (id_wr && ioctl_addr == `CART_ID_DECIDE) begin
				quirks.sram   <= quirks.sram | hit.sram;
				quirks.eeprom <= quirks.eeprom | hit.eeprom;
				quirks.noram  <= quirks.noram | hit.noram;
				quirks.fifo   <= quirks.fifo | hit.fifo;
				quirks.pier   <= quirks.pier | hit.pier;
				quirks.svp    <= quirks.svp | hit.svp;
				quirks.fmbusy <= quirks.fmbusy | hit.fmbusy;
				quirks.schan  <= quirks.schan | hit.schan;
				quirks.gun_type         <= hit.gun_type;
				quirks.gun_sensor_delay <= hit.gun_sensor_delay;
			end
		end
	end

	// One title, one quirk, across the whole download
	single_quirk: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0({quirks.sram, quirks.eeprom, quirks.noram, quirks.fifo,
			quirks.pier, quirks.svp, quirks.fmbusy, quirks.schan}));

endmodule

// File: verilog/region_select.sv
// Automatic region selection
`timescale 1ns/1ns

module region_select (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic [7:0]              ioctl_index,
	input  cart_pkg::region_mode_t  region_mode,
	input  cart_pkg::region_prio_t  region_prio,
	input  cart_pkg::region_flags_t hdr_flags,
	input  logic                    hdr_ready,
	output cart_pkg::region_t       region_req,
	output logic                    region_set
);

	logic              rdy_q1;
	logic              rdy_q2;
	cart_pkg::region_t first;
	cart_pkg::region_t second;
	cart_pkg::region_t third;
	cart_pkg::region_t hdr_pick;

	function automatic logic has_flag(input cart_pkg::region_flags_t f,
		input cart_pkg::region_t r);
		case (r)
			cart_pkg::REGION_JP: return f.j;
			cart_pkg::REGION_US: return f.u;
			default:             return f.e;
		endcase
	endfunction

	// Priority order as three slots
	always_comb begin
		case (region_prio)
			cart_pkg::PRIO_US_EU_JP: {first, second, third} = {cart_pkg::REGION_US, cart_pkg::REGION_EU, cart_pkg::REGION_JP};
			cart_pkg::PRIO_EU_US_JP: {first, second, third} = {cart_pkg::REGION_EU, cart_pkg::REGION_US, cart_pkg::REGION_JP};
			cart_pkg::PRIO_US_JP_EU: {first, second, third} = {cart_pkg::REGION_US, cart_pkg::REGION_JP, cart_pkg::REGION_EU};
			default:                 {first, second, third} = {cart_pkg::REGION_JP, cart_pkg::REGION_US, cart_pkg::REGION_EU};
		endcase
	end

	assign hdr_pick = has_flag(hdr_flags, first)  ? first  :
	                  has_flag(hdr_flags, second) ? second :
	                  has_flag(hdr_flags, third)  ? third  : first;  // Nothing found

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rdy_q1     <= 1'b0;
			rdy_q2     <= 1'b0;
			region_req <= cart_pkg::REGION_JP;
			region_set <= 1'b0;
		end else begin
			rdy_q1 <= hdr_ready;
			rdy_q2 <= rdy_q1;
			if (rdy_q1 && !rdy_q2) begin
				case (region_mode)
					cart_pkg::MODE_HEADER: begin
						region_req <= hdr_pick;
						region_set <= 1'b1;
					end
					cart_pkg::MODE_FILE_EXT: begin  // Extension coded in the index
						region_req <= cart_pkg::region_t'(ioctl_index[7:6]);
						region_set <= |ioctl_index;
					end
					default: ;
				endcase
			end
			if (!rdy_q1 && rdy_q2) region_set <= 1'b0;
		end
	end

endmodule

// File: verilog/backup_sequencer.sv
// Backup RAM load/save sequencer
`timescale 1ns/1ns
`include "cart_cfg.svh"

module backup_sequencer (
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        ioctl_download,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_size_nonzero,
	input  logic        no_backup,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_loading,
	output logic        bk_busy
);

	logic dl_d, load_d, save_d, ack_d;
	logic bk_ena;
	logic auto_load;
	logic start_any;
	logic start_loading;
	logic ack_fall;
	logic last_sector;

	assign auto_load     = dl_d & ~ioctl_download & img_size_nonzero;
	assign start_any     = !bk_busy && bk_ena &&
	                       ((!load_d && bk_load) || (!save_d && bk_save) || auto_load);
	assign start_loading = auto_load | bk_load;
	assign ack_fall      = ack_d & ~sd_ack;
	assign last_sector   = sd_lba == `CART_BK_SECTORS - 1;

	////////////////////////////////////////
	// Control
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{dl_d, load_d, save_d, ack_d} <= '0;
			bk_ena     <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			{dl_d, load_d, save_d, ack_d} <= {ioctl_download, bk_load, bk_save, sd_ack};
			if (!dl_d && ioctl_download) bk_ena <= 1'b0;
			if (ioctl_download) begin  // Image is mounted by the end of the download
				if (img_mounted && !img_readonly && !no_backup) bk_ena <= 1'b1;
				else if (no_backup) bk_ena <= 1'b0;
			end

			if (!ack_d && sd_ack) {sd_rd, sd_wr} <= 2'b00;  // Request taken

			if (start_any) begin
				bk_busy    <= 1'b1;
				bk_loading <= start_loading;
				sd_rd      <= start_loading;
				sd_wr      <= ~start_loading;
			end else if (bk_busy && ack_fall) begin
				if (last_sector) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_rd <= bk_loading;
					sd_wr <= ~bk_loading;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_any) sd_lba <= '0;
		else if (bk_busy && ack_fall && !last_sector) sd_lba <= sd_lba + 32'd1;
	end

	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr));

endmodule

// File: verilog/cart_loader.sv
// Cartridge loader top level
`timescale 1ns/1ns
`include "cart_cfg.svh"

module cart_loader (
	input  logic                    clk_sys,
	input  logic                    RESET,

	// Download port
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`CART_ADDR_W-1:0] ioctl_addr,
	input  logic [`CART_DATA_W-1:0] ioctl_data,
	input  logic [7:0]              ioctl_index,
	output logic                    ioctl_wait,

	// ROM memory
	output logic                    rom_req,
	input  logic                    rom_ack,
	output logic [`CART_ADDR_W-2:0] rom_addr,
	output logic [`CART_DATA_W-1:0] rom_wdata,
	output logic [`CART_ADDR_W-1:0] rom_size,

	// Region
	input  cart_pkg::region_mode_t  region_mode,
	input  cart_pkg::region_prio_t  region_prio,
	output cart_pkg::region_t       region_req,
	output logic                    region_set,

	output cart_pkg::cart_quirks_t  quirks,

	// Backup RAM on SD
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic                    img_size_nonzero,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    sd_ack,
	output logic [31:0]             sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output logic                    bk_loading,
	output logic                    bk_busy
);

	cart_pkg::region_flags_t hdr_flags;
	logic                    hdr_ready;

	rom_write_pacer pacer_i (
		.clk_sys, .RESET, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.rom_ack, .rom_req, .rom_addr, .rom_wdata, .ioctl_wait, .rom_size
	);

	header_region_scan scan_i (
		.clk_sys, .RESET, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.hdr_flags, .hdr_ready
	);

	cart_id_quirks id_i (
		.clk_sys, .RESET, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_data, .quirks
	);

	region_select region_i (
		.clk_sys, .RESET, .ioctl_index, .region_mode, .region_prio,
		.hdr_flags, .hdr_ready, .region_req, .region_set
	);

	backup_sequencer backup_i (
		.clk_sys, .RESET, .ioctl_download, .img_mounted, .img_readonly, .img_size_nonzero,
		.no_backup(quirks.svp),  // No backup RAM with the DSP cart
		.bk_load, .bk_save, .sd_ack, .sd_lba, .sd_rd, .sd_wr, .bk_loading, .bk_busy
	);

endmodule

// File: testbench/cart_loader_tb.sv
// Cartridge loader testbench
`timescale 1ns/1ns
`include "cart_cfg.svh"

module cart_loader_tb;

	localparam int CLK_PERIOD  = 20;
	localparam int IMAGE_WORDS = 264;  // Up to 'h20E past the header end
	localparam int DOWNLOADS   = 3;
	localparam int BACKUP_RUNS = 2;
	localparam int WATCHDOG_CYCLES = DOWNLOADS * IMAGE_WORDS * 12
		+ BACKUP_RUNS * `CART_BK_SECTORS * 20 + 1000;

	logic                    clk_sys;
	logic                    RESET;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [`CART_ADDR_W-1:0] ioctl_addr;
	logic [`CART_DATA_W-1:0] ioctl_data;
	logic [7:0]              ioctl_index;
	logic                    ioctl_wait;
	logic                    rom_req;
	logic                    rom_ack;
	logic [`CART_ADDR_W-2:0] rom_addr;
	logic [`CART_DATA_W-1:0] rom_wdata;
	logic [`CART_ADDR_W-1:0] rom_size;
	cart_pkg::region_mode_t  region_mode;
	cart_pkg::region_prio_t  region_prio;
	cart_pkg::region_t       region_req;
	logic                    region_set;
	cart_pkg::cart_quirks_t  quirks;
	logic                    img_mounted;
	logic                    img_readonly;
	logic                    img_size_nonzero;
	logic                    bk_load;
	logic                    bk_save;
	logic                    sd_ack;
	logic [31:0]             sd_lba;
	logic                    sd_rd;
	logic                    sd_wr;
	logic                    bk_loading;
	logic                    bk_busy;

	// Expectations set by each test
	cart_pkg::region_t       exp_region;
	cart_pkg::cart_quirks_t  exp_quirks;
	logic [`CART_ADDR_W-1:0] last_addr;
	logic                    backup_allowed;
	logic                    exp_load;
	logic [31:0]             sectors_done;  // Counted by the SD model
	logic [15:0]             lfsr_state;
	logic [7:0]              quirk_flags;

	assign quirk_flags = {quirks.sram, quirks.eeprom, quirks.noram, quirks.fifo,
		quirks.pier, quirks.svp, quirks.fmbusy, quirks.schan};

	cart_loader dut_i (
		.clk_sys, .RESET, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_data,
		.ioctl_index, .ioctl_wait, .rom_req, .rom_ack, .rom_addr, .rom_wdata, .rom_size,
		.region_mode, .region_prio, .region_req, .region_set, .quirks,
		.img_mounted, .img_readonly, .img_size_nonzero, .bk_load, .bk_save, .sd_ack,
		.sd_lba, .sd_rd, .sd_wr, .bk_loading, .bk_busy
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		stop_run($sformatf("error at %0t ns: %s", $time, msg));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			value      = (value << 1) | int'(lfsr_state[15]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Serial and region words over an address pattern
	function automatic logic [15:0] image_word(input logic [`CART_ADDR_W-1:0] a,
		input logic [63:0] sn, input logic [15:0] hdr_a, input logic [15:0] hdr_b);
		case (32'(a))
			`CART_ID_FIRST:      return {sn[63:56], 8'h20};
			`CART_ID_FIRST + 2:  return {sn[47:40], sn[55:48]};
			`CART_ID_FIRST + 4:  return {sn[31:24], sn[39:32]};
			`CART_ID_FIRST + 6:  return {sn[15:8], sn[23:16]};
			`CART_ID_FIRST + 8:  return {8'h20, sn[7:0]};
			`CART_HDR_REGION_A:  return hdr_a;
			`CART_HDR_REGION_B:  return hdr_b;
			default:             return a[15:0] ^ {a[24:16], 7'h55} ^ 16'h3C5A;
		endcase
	endfunction

	task automatic download_image(input logic [63:0] sn, input logic [15:0] hdr_a,
		input logic [15:0] hdr_b);
		logic [`CART_ADDR_W-1:0] addr;
		@(negedge clk_sys);
		ioctl_download = 1'b1;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			addr = `CART_ADDR_W'(2 * i);
			@(negedge clk_sys);
			ioctl_wr   = 1'b1;
			ioctl_addr = addr;
			ioctl_data = image_word(addr, sn, hdr_a, hdr_b);
			last_addr  = addr;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			while (ioctl_wait) @(negedge clk_sys);  // Memory still busy
		end
		ioctl_download = 1'b0;  // Address stays on the last word
	endtask

	task automatic wait_backup_run();
		while (!bk_busy) @(negedge clk_sys);
		while (bk_busy) @(negedge clk_sys);
	endtask

	////////////////////////////////////////
	// Memory and SD card models

	initial begin
		int delay;
		wait (!RESET);
		forever begin
			@(negedge clk_sys);
			if (rom_req !== rom_ack) begin
				take_bits(3, delay);
				repeat (delay) @(negedge clk_sys);
				rom_ack = rom_req;  // Toggle acknowledge
			end
		end
	end

	initial begin
		int delay;
		int width;
		wait (!RESET);
		forever begin
			@(negedge clk_sys);
			if ((sd_rd || sd_wr) && !sd_ack) begin
				take_bits(2, delay);
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				take_bits(2, width);
				repeat (width + 1) @(negedge clk_sys);
				sd_ack       = 1'b0;
				sectors_done = sectors_done + 32'd1;
			end
		end
	end

	////////////////////////////////////////
	// Checks

	after_reset_state: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(RESET) |-> !ioctl_wait && !rom_req && !region_set && !bk_busy && !sd_rd
			&& !sd_wr && !dut_i.hdr_ready && quirk_flags == 8'h00
			&& quirks.gun_sensor_delay == 8'd44)
		else value_error("outputs not in their reset state");

	rom_req_toggles: assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_req != $past(rom_req)) == $past(ioctl_download && ioctl_wr))
		else value_error("rom_req did not toggle exactly once per write");

	rom_word_fields: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_download && ioctl_wr) |->
			rom_addr == $past(ioctl_addr[`CART_ADDR_W-1:1])
			&& rom_wdata == {$past(ioctl_data[7:0]), $past(ioctl_data[15:8])})
		else value_error("wrong ROM word address or byte order");

	wait_rises: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_download && ioctl_wr) |-> ioctl_wait)
		else value_error("ioctl_wait did not rise after a write");

	wait_holds: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_wait && (rom_ack != rom_req)) |-> ioctl_wait)
		else value_error("ioctl_wait fell before the acknowledge");

	wait_drops: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_wait && (rom_ack == rom_req)) |-> !ioctl_wait)
		else value_error("ioctl_wait stayed high after the acknowledge");

	rom_size_captured: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_download, 2) && !$past(ioctl_download) |-> rom_size == last_addr)
		else value_error("rom_size differs from the last address");

	region_value: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |-> region_req == exp_region)
		else value_error("wrong region_req");

	region_set_during_header: assert property (@(posedge clk_sys) disable iff (RESET)
		dut_i.hdr_ready && $past(dut_i.hdr_ready, 2) |-> region_set)
		else value_error("region_set low while the header is ready");

	region_clear_after: assert property (@(posedge clk_sys) disable iff (RESET)
		!ioctl_download && !$past(ioctl_download) && !$past(ioctl_download, 2)
			&& !$past(ioctl_download, 3) |-> !region_set)
		else value_error("region_set still high after the download");

	quirks_decided: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_download && ioctl_wr && ioctl_addr == `CART_ID_DECIDE)
			|-> quirks == exp_quirks)
		else value_error("wrong quirks after the serial number");

	flags_cleared: assert property (@(posedge clk_sys) disable iff (RESET)
		$past(ioctl_download) && !$past(ioctl_download, 2) |-> quirk_flags == 8'h00)
		else value_error("quirk flags not cleared at download start");

	sector_order: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(sd_rd || sd_wr) |->
			sd_lba == sectors_done && sd_rd == exp_load && sd_wr == !exp_load)
		else value_error("wrong sector or direction on an SD request");

	requests_inside_busy: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd_rd || sd_wr) |-> bk_busy)
		else value_error("SD request outside a backup run");

	loading_flag: assert property (@(posedge clk_sys) disable iff (RESET)
		bk_loading == (bk_busy && exp_load))
		else value_error("bk_loading does not match the running transfer");

	busy_end: assert property (@(posedge clk_sys) disable iff (RESET)
		$fell(bk_busy) |-> $past(sectors_done) == `CART_BK_SECTORS
			&& !$past(sd_ack) && $past(sd_ack, 2))
		else value_error("bk_busy fell at the wrong time");

	backup_blocked: assert property (@(posedge clk_sys) disable iff (RESET)
		!backup_allowed |-> !bk_busy)
		else value_error("backup run started while it is not allowed");

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_run("Watchdog expired before the tests finished");
	end

	////////////////////////////////////////
	// Test sequence

	initial begin
		clk_sys          = 1'b0;
		RESET            = 1'b1;
		ioctl_download   = 1'b0;
		ioctl_wr         = 1'b0;
		ioctl_addr       = '0;
		ioctl_data       = '0;
		ioctl_index      = 8'h01;
		rom_ack          = 1'b0;
		region_mode      = cart_pkg::MODE_HEADER;
		region_prio      = cart_pkg::PRIO_EU_US_JP;
		img_mounted      = 1'b0;
		img_readonly     = 1'b0;
		img_size_nonzero = 1'b0;
		bk_load          = 1'b0;
		bk_save          = 1'b0;
		sd_ack           = 1'b0;
		lfsr_state       = 16'd46299;
		exp_region       = cart_pkg::REGION_US;
		exp_quirks       = '0;
		last_addr        = '0;
		backup_allowed   = 1'b0;
		exp_load         = 1'b1;
		sectors_done     = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		RESET = 1'b0;
		repeat (3) @(negedge clk_sys);

		// Light gun title with a "U" header and a load then a save
		exp_quirks                  = '0;
		exp_quirks.gun_type         = 1'b1;
		exp_quirks.gun_sensor_delay = 8'd52;
		img_mounted      = 1'b1;
		img_size_nonzero = 1'b1;
		backup_allowed   = 1'b1;
		download_image("T-95096-", 16'h2055, 16'h2020);
		wait_backup_run();
		exp_load     = 1'b0;
		sectors_done = '0;
		bk_save      = 1'b1;
		wait_backup_run();
		bk_save = 1'b0;

		// No region letters on a read-only image
		backup_allowed = 1'b0;
		img_readonly   = 1'b1;
		region_prio    = cart_pkg::PRIO_JP_US_EU;
		exp_region     = cart_pkg::REGION_JP;
		exp_quirks                  = '0;
		exp_quirks.eeprom           = 1'b1;
		exp_quirks.gun_sensor_delay = 8'd44;
		download_image("MK-1215 ", 16'h2020, 16'h2020);
		repeat (10) @(negedge clk_sys);
		bk_load = 1'b1;
		repeat (20) @(negedge clk_sys);
		bk_load = 1'b0;

		// DSP cart with the region from the file extension index
		img_readonly = 1'b0;
		region_mode  = cart_pkg::MODE_FILE_EXT;
		ioctl_index  = 8'h80;
		exp_region   = cart_pkg::REGION_EU;
		exp_quirks                  = '0;
		exp_quirks.svp              = 1'b1;
		exp_quirks.gun_sensor_delay = 8'd44;
		download_image("MK-1229 ", {"J", "E"}, 16'h2020);
		repeat (10) @(negedge clk_sys);
		bk_save = 1'b1;
		repeat (20) @(negedge clk_sys);
		bk_save = 1'b0;
		repeat (10) @(negedge clk_sys);

		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: cart_loader.f
+incdir+verilog
verilog/cart_pkg.sv
verilog/rom_write_pacer.sv
verilog/header_region_scan.sv
verilog/cart_id_quirks.sv
verilog/region_select.sv
verilog/backup_sequencer.sv
verilog/cart_loader.sv
testbench/cart_loader_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f cart_loader.f --top-module cart_loader_tb \
	--Mdir obj_dir -o cart_loader_sim

sim_out="$(./obj_dir/cart_loader_sim 2>&1)" || true
printf '%s\n' "$sim_out"

if grep -qx "TEST PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1
